//--- include/frontend_params.svh
//////////////////////////////////////////////////////////////////////
// Build-wide sizing constants for the instruction front end.
// Include wherever a data width, buffer depth or the boot address
// is needed. Packages carry the types built from these values.
//////////////////////////////////////////////////////////////////////

`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// Data and address width of the core
`define XLEN 32

// Entries in the fetch buffer
// Depths above two are rounded up to a power of two
`define FETCH_FIFO_DEPTH 4

// First fetch address after reset
`define RESET_PC 32'h0000_1000

`endif

//--- rtl/riscv_isa_pkg.sv
//////////////////////////////////////////////////////////////////////
// RV32I instruction-set types shared by the decoder and testbench.
// Holds the raw word, register address, immediate and the major
// opcode encodings. No front-end specific types live here.
//////////////////////////////////////////////////////////////////////

`include "frontend_params.svh"

package riscv_isa_pkg;

    // Raw 32-bit instruction word
    typedef logic [31:0] instr_t;

    // Architectural register index, x0 to x31
    typedef logic [4:0] reg_addr_t;

    // Immediate after sign extension to full width
    typedef logic [`XLEN-1:0] imm_t;

    //////////////////////////////////////////////////////////////////
    // Major opcodes, bits [6:0] of the word
    //////////////////////////////////////////////////////////////////
    // Values are the ISA encodings, low two bits always 11
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcode_t;

endpackage

//--- rtl/frontend_pkg.sv
//////////////////////////////////////////////////////////////////////
// Front-end types for fetch, buffering and decode.
// Defines the fetch address, the buffered packet and the fetch FSM
// states. Instruction-level types come from the ISA package.
//////////////////////////////////////////////////////////////////////

`include "frontend_params.svh"

package frontend_pkg;

    // Fetch address, byte granular
    typedef logic [`XLEN-1:0] pc_t;

    // One buffer entry, address in the upper half
    typedef struct packed {
        pc_t                  pc;
        riscv_isa_pkg::instr_t instr;
    } fetch_packet_t;

    // Single outstanding request, so two states suffice
    typedef enum logic {
        FETCH_IDLE = 1'b0,
        FETCH_WAIT = 1'b1
    } fetch_state_t;

endpackage

//--- rtl/lfsr.sv
//////////////////////////////////////////////////////////////////////
// Maximal-length LFSR with zero insertion, stepping on en.
// Covers all 2^width values, so it serves as a cheap FIFO pointer.
// Resets to zero. Tap table covers widths 1 to 12.
//////////////////////////////////////////////////////////////////////

module lfsr #(
    parameter int width = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    output logic [width-1:0] value
);

    // Feedback taps per width, MSB tap always present
    function automatic logic [31:0] tap_mask(input int w);
        logic [31:0] mask;
        case (w)
            2:       mask = 32'h0000_0003;
            3:       mask = 32'h0000_0006;
            4:       mask = 32'h0000_000c;
            5:       mask = 32'h0000_0014;
            6:       mask = 32'h0000_0030;
            7:       mask = 32'h0000_0060;
            8:       mask = 32'h0000_00b8;
            9:       mask = 32'h0000_0110;
            10:      mask = 32'h0000_0240;
            11:      mask = 32'h0000_0500;
            default: mask = 32'h0000_0829;
        endcase
        return mask;
    endfunction

    generate
    if (width == 1) begin : g_toggle
        // One bit has only two states
        always_ff @(posedge clk) begin
            if (rst)
                value <= 1'b0;
            else if (en)
                value <= ~value;
        end
    end else begin : g_shift
        localparam logic [31:0] taps = tap_mask(width);
        logic feedback;

        // Zero term splices the all-zero state into the cycle
        assign feedback = (^(value & taps[width-1:0])) ^ (value[width-2:0] == '0);

        always_ff @(posedge clk) begin
            if (rst)
                value <= '0;
            else if (en)
                value <= {value[width-2:0], feedback};
        end
    end
    endgenerate

endmodule

//--- rtl/fetch_fifo.sv
//////////////////////////////////////////////////////////////////////
// Small FIFO for fetched instructions, implementation picked by depth.
// Not overflow or underflow safe: push only when full is low (or
// alongside a pop), pop only while valid is high. data_out shows the
// oldest entry whenever valid is high.
//////////////////////////////////////////////////////////////////////

module fetch_fifo #(
    parameter int data_width = 64,
    parameter int fifo_depth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  logic                  pop,
    input  logic [data_width-1:0] data_in,
    output logic                  valid,
    output logic                  full,
    output logic [data_width-1:0] data_out
);

    localparam int log2_depth = $clog2(fifo_depth);

    generate
    //////////////////////////////////////////////////////////////////
    // Depth 1
    //////////////////////////////////////////////////////////////////
    if (fifo_depth == 1) begin : g_single
        always_ff @(posedge clk) begin
            if (rst)
                valid <= 1'b0;
            else
                valid <= push | (valid & ~pop);
        end

        // One slot, so occupied means full
        assign full = valid;

        always_ff @(posedge clk) begin
            if (push)
                data_out <= data_in;
        end
    end else begin : g_multi
        //////////////////////////////////////////////////////////////
        // Occupancy tracking
        //////////////////////////////////////////////////////////////
        // Counts down from zero on push, so the top bit flags any
        // occupancy and a wrap to 100..0 flags a full buffer
        logic [log2_depth:0] inflight_count;

        always_ff @(posedge clk) begin
            if (rst)
                inflight_count <= '0;
            else
                inflight_count <= inflight_count
                                + (log2_depth+1)'(pop)
                                - (log2_depth+1)'(push);
        end

        assign valid = inflight_count[log2_depth];
        assign full  = valid & ~|inflight_count[log2_depth-1:0];

        if (fifo_depth == 2) begin : g_shift
            // Two registers, newest in slot 0
            logic [data_width-1:0] shift_reg [2];

            always_ff @(posedge clk) begin
                if (push) begin
                    shift_reg[0] <= data_in;
                    shift_reg[1] <= shift_reg[0];
                end
            end

            // One entry sits in slot 0, two entries put the head in slot 1
            assign data_out = shift_reg[~inflight_count[0]];
        end else begin : g_lutram
            // Depth rounded up to a power of two
            logic [data_width-1:0] lut_ram [2**log2_depth];
            logic [log2_depth-1:0] write_index;
            logic [log2_depth-1:0] read_index;

            // Both pointers walk the same LFSR sequence
            lfsr #(.width(log2_depth)) read_index_gen (
                .clk   (clk),
                .rst   (rst),
                .en    (pop),
                .value (read_index)
            );

            lfsr #(.width(log2_depth)) write_index_gen (
                .clk   (clk),
                .rst   (rst),
                .en    (push),
                .value (write_index)
            );

            always_ff @(posedge clk) begin
                if (push)
                    lut_ram[write_index] <= data_in;
            end

            // Asynchronous read of the head
            assign data_out = lut_ram[read_index];
        end
    end
    endgenerate

endmodule

//--- rtl/fetch_unit.sv
//////////////////////////////////////////////////////////////////////
// Sequential instruction fetch with one memory request in flight.
// Requests only while enabled and the buffer has room; each response
// is pushed into the fetch buffer with its address on arrival.
//////////////////////////////////////////////////////////////////////

`include "frontend_params.svh"

module fetch_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_en,
    input  logic                        mem_resp_valid,
    input  logic                        full,
    input  riscv_isa_pkg::instr_t       mem_resp_data,
    output logic                        mem_req,
    output logic                        push,
    output frontend_pkg::pc_t           mem_addr,
    output frontend_pkg::fetch_packet_t data_in
);

    import frontend_pkg::*;

    fetch_state_t state;
    pc_t          pc;
    logic         resp_accept;

    //////////////////////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////////////////////
    // Not full here means the slot for this response is reserved,
    // nothing else pushes
    assign mem_req  = (state == FETCH_IDLE) & fetch_en & ~full;
    assign mem_addr = pc;

    // Response only counts while a request is open
    assign resp_accept = (state == FETCH_WAIT) & mem_resp_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH_IDLE;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (mem_req)
                        state <= FETCH_WAIT;
                end
                FETCH_WAIT: begin
                    if (resp_accept)
                        state <= FETCH_IDLE;
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // Address holds while waiting, so it tags the returning word
    always_ff @(posedge clk) begin
        if (rst)
            pc <= `RESET_PC;
        else if (resp_accept)
            pc <= pc + pc_t'(4);
    end

    //////////////////////////////////////////////////////////////////
    // Buffer write
    //////////////////////////////////////////////////////////////////
    assign push          = resp_accept;
    assign data_in.pc    = pc;
    assign data_in.instr = mem_resp_data;

endmodule

//--- rtl/decode_unit.sv
//////////////////////////////////////////////////////////////////////
// Instruction decode between the fetch buffer and the issue stage.
// Pops the head when the output register is free or being taken,
// and registers address, register fields, opcode class, immediate
// and an illegal flag. Outputs hold while issue_ready is low.
//////////////////////////////////////////////////////////////////////

module decode_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid,
    input  logic                        issue_ready,
    input  frontend_pkg::fetch_packet_t data_out,
    output logic                        pop,
    output logic                        dec_valid,
    output logic                        dec_illegal,
    output frontend_pkg::pc_t           dec_pc,
    output riscv_isa_pkg::opcode_t      dec_opcode,
    output riscv_isa_pkg::reg_addr_t    dec_rd,
    output riscv_isa_pkg::reg_addr_t    dec_rs1,
    output riscv_isa_pkg::reg_addr_t    dec_rs2,
    output riscv_isa_pkg::imm_t         dec_imm
);

    import riscv_isa_pkg::*;

    instr_t  instr;
    opcode_t opcode;
    imm_t    imm;
    logic    illegal;
    logic    load;

    assign instr  = data_out.instr;
    assign opcode = opcode_t'(instr[6:0]);

    //////////////////////////////////////////////////////////////////
    // Immediate extraction
    //////////////////////////////////////////////////////////////////
    always_comb begin
        imm     = '0;
        illegal = 1'b0;
        case (opcode)
            // I-type
            JALR, LOAD, OP_IMM, SYSTEM:
                imm = imm_t'($signed(instr[31:20]));
            // S-type
            STORE:
                imm = imm_t'($signed({instr[31:25], instr[11:7]}));
            // B-type, bit 0 always zero
            BRANCH:
                imm = imm_t'($signed({instr[31], instr[7], instr[30:25],
                                      instr[11:8], 1'b0}));
            // U-type, upper 20 bits
            LUI, AUIPC:
                imm = imm_t'($signed({instr[31:12], 12'b0}));
            // J-type
            JAL:
                imm = imm_t'($signed({instr[31], instr[19:12], instr[20],
                                      instr[30:21], 1'b0}));
            // R-type has no immediate
            OP:
                imm = '0;
            default:
                illegal = 1'b1;
        endcase

        // Non-32-bit encodings are rejected outright
        if (instr[1:0] != 2'b11) begin
            illegal = 1'b1;
            imm     = '0;
        end
    end

    //////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////
    // Take the head if the slot is empty or drains this cycle
    assign load = valid & (~dec_valid | issue_ready);
    assign pop  = load;

    always_ff @(posedge clk) begin
        if (rst)
            dec_valid <= 1'b0;
        else if (load)
            dec_valid <= 1'b1;
        else if (issue_ready)
            dec_valid <= 1'b0;
    end

    // Payload moves only on load, so it stays put under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            dec_pc      <= data_out.pc;
            dec_opcode  <= opcode;
            dec_rd      <= instr[11:7];
            dec_rs1     <= instr[19:15];
            dec_rs2     <= instr[24:20];
            dec_imm     <= imm;
            dec_illegal <= illegal;
        end
    end

endmodule

//--- rtl/fetch_decode_top.sv
//////////////////////////////////////////////////////////////////////
// Instruction front end: fetch unit, fetch buffer and decode unit.
// Connects to an instruction memory with variable latency and to an
// issue stage that accepts one decoded instruction per ready cycle.
//////////////////////////////////////////////////////////////////////

`include "frontend_params.svh"

module fetch_decode_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetch_en,
    input  logic                     mem_resp_valid,
    input  riscv_isa_pkg::instr_t    mem_resp_data,
    input  logic                     issue_ready,
    output logic                     mem_req,
    output frontend_pkg::pc_t        mem_addr,
    output logic                     dec_valid,
    output frontend_pkg::pc_t        dec_pc,
    output riscv_isa_pkg::opcode_t   dec_opcode,
    output riscv_isa_pkg::reg_addr_t dec_rd,
    output riscv_isa_pkg::reg_addr_t dec_rs1,
    output riscv_isa_pkg::reg_addr_t dec_rs2,
    output riscv_isa_pkg::imm_t      dec_imm,
    output logic                     dec_illegal
);

    import frontend_pkg::*;

    // Buffer handshake
    logic          push;
    logic          pop;
    logic          valid;
    logic          full;
    fetch_packet_t data_in;
    fetch_packet_t data_out;

    fetch_unit fetch (
        .clk            (clk),
        .rst            (rst),
        .fetch_en       (fetch_en),
        .mem_resp_valid (mem_resp_valid),
        .full           (full),
        .mem_resp_data  (mem_resp_data),
        .mem_req        (mem_req),
        .push           (push),
        .mem_addr       (mem_addr),
        .data_in        (data_in)
    );

    fetch_fifo #(
        .data_width ($bits(fetch_packet_t)),
        .fifo_depth (`FETCH_FIFO_DEPTH)
    ) buffer (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .pop      (pop),
        .data_in  (data_in),
        .valid    (valid),
        .full     (full),
        .data_out (data_out)
    );

    decode_unit decode (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .issue_ready (issue_ready),
        .data_out    (data_out),
        .pop         (pop),
        .dec_valid   (dec_valid),
        .dec_illegal (dec_illegal),
        .dec_pc      (dec_pc),
        .dec_opcode  (dec_opcode),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_imm     (dec_imm)
    );

endmodule

//--- testbench/fetch_decode_checker.sv
//////////////////////////////////////////////////////////////////////
// Protocol assertions for the instruction front end.
// Bound to the top level. Watches the memory request rule, the
// buffer flags and the decode output under back-pressure.
//////////////////////////////////////////////////////////////////////

`include "frontend_params.svh"

module fetch_decode_checker (
    input logic             clk,
    input logic             rst,
    input logic             mem_req,
    input logic             mem_resp_valid,
    input logic             push,
    input logic             pop,
    input logic             valid,
    input logic             full,
    input logic             issue_ready,
    input logic             dec_valid,
    input logic             dec_illegal,
    input logic [`XLEN-1:0] dec_pc,
    input logic [`XLEN-1:0] dec_imm,
    input logic [6:0]       dec_opcode,
    input logic [4:0]       dec_rd,
    input logic [4:0]       dec_rs1,
    input logic [4:0]       dec_rs2
);

    // Open between a request and its response
    logic req_open;

    // Buffer occupancy rebuilt from the push and pop strobes
    int entries;

    always_ff @(posedge clk) begin
        if (rst)
            req_open <= 1'b0;
        else if (mem_req)
            req_open <= 1'b1;
        else if (mem_resp_valid)
            req_open <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst)
            entries <= 0;
        else
            entries <= entries + int'(push) - int'(pop);
    end

    //////////////////////////////////////////////////////////////////////
    // Memory and buffer rules
    //////////////////////////////////////////////////////////////////////
    a_single_request: assert property (@(posedge clk) disable iff (rst)
        req_open |-> !mem_req)
        else $error("memory request raised while another is outstanding");

    a_push_not_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else $error("fetch buffer pushed while full");

    a_valid_flag: assert property (@(posedge clk) disable iff (rst)
        valid == (entries != 0))
        else $error("fetch buffer valid flag disagrees with its occupancy");

    a_pop_valid: assert property (@(posedge clk) disable iff (rst)
        pop |-> entries != 0)
        else $error("fetch buffer popped while empty");

    // Stalled output keeps every field
    a_hold_outputs: assert property (@(posedge clk) disable iff (rst)
        (dec_valid && !issue_ready) |=>
            (dec_valid && $stable(dec_pc) && $stable(dec_imm)
             && $stable(dec_opcode) && $stable(dec_rd) && $stable(dec_rs1)
             && $stable(dec_rs2) && $stable(dec_illegal)))
        else $error("decode output changed while issue stage stalled");

endmodule

bind fetch_decode_top fetch_decode_checker checker_inst (
    .clk            (clk),
    .rst            (rst),
    .mem_req        (mem_req),
    .mem_resp_valid (mem_resp_valid),
    .push           (push),
    .pop            (pop),
    .valid          (valid),
    .full           (full),
    .issue_ready    (issue_ready),
    .dec_valid      (dec_valid),
    .dec_illegal    (dec_illegal),
    .dec_pc         (dec_pc),
    .dec_imm        (dec_imm),
    .dec_opcode     (dec_opcode),
    .dec_rd         (dec_rd),
    .dec_rs1        (dec_rs1),
    .dec_rs2        (dec_rs2)
);

//--- testbench/fetch_decode_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the instruction front end.
// Variable-latency memory model serves a table of instructions, the
// issue side toggles ready at random, and each accepted output is
// compared in order with the table's expected decode.
//////////////////////////////////////////////////////////////////////

`include "frontend_params.svh"

module fetch_decode_tb;

    import riscv_isa_pkg::*;

    localparam int num_rows     = 16;
    localparam int wait_limit   = 200;
    localparam int stall_cycles = 20;
    localparam int stall_row    = 6;

    logic              clk;
    logic              rst;
    logic              fetch_en;
    logic              mem_resp_valid;
    instr_t            mem_resp_data;
    logic              issue_ready;
    logic              mem_req;
    logic [`XLEN-1:0]  mem_addr;
    logic              dec_valid;
    logic [`XLEN-1:0]  dec_pc;
    opcode_t           dec_opcode;
    reg_addr_t         dec_rd;
    reg_addr_t         dec_rs1;
    reg_addr_t         dec_rs2;
    imm_t              dec_imm;
    logic              dec_illegal;

    integer seed = 32'hc6d8_9a84;
    int     value_errors = 0;
    int     other_errors = 0;

    // Instruction table with expected decode
    instr_t    tbl_instr   [num_rows];
    opcode_t   tbl_opcode  [num_rows];
    reg_addr_t tbl_rd      [num_rows];
    reg_addr_t tbl_rs1     [num_rows];
    reg_addr_t tbl_rs2     [num_rows];
    imm_t      tbl_imm     [num_rows];
    logic      tbl_illegal [num_rows];

    // Memory model state
    logic mem_busy;
    int   mem_wait;
    int   mem_index;
    int   req_count;

    // Instructions fetched but not yet taken by the issue stage
    int   in_flight;

    fetch_decode_top dut (
        .clk            (clk),
        .rst            (rst),
        .fetch_en       (fetch_en),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .issue_ready    (issue_ready),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_opcode     (dec_opcode),
        .dec_rd         (dec_rd),
        .dec_rs1        (dec_rs1),
        .dec_rs2        (dec_rs2),
        .dec_imm        (dec_imm),
        .dec_illegal    (dec_illegal)
    );

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Memory model answering each request after 1 to 4 cycles
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            mem_resp_valid <= 1'b0;
            mem_busy       <= 1'b0;
            req_count      <= 0;
        end else begin
            mem_resp_valid <= 1'b0;
            if (mem_req) begin
                if (mem_busy) begin
                    other_errors++;
                    $display("Memory request arrived while another was outstanding");
                end
                if (req_count == 0 && mem_addr !== `RESET_PC) begin
                    value_errors++;
                    $display("Fail at %0t: mem_addr got %h expected %h",
                             $time, mem_addr, `RESET_PC);
                end
                mem_busy  <= 1'b1;
                mem_wait  <= 1 + ($unsigned($random(seed)) % 4);
                mem_index <= (mem_addr - `RESET_PC) / 4;
                req_count <= req_count + 1;
                // Whole table requested
                if (req_count == num_rows - 1)
                    fetch_en <= 1'b0;
            end else if (mem_busy) begin
                if (mem_wait == 1) begin
                    mem_resp_valid <= 1'b1;
                    mem_resp_data  <= (mem_index < num_rows) ? tbl_instr[mem_index]
                                                             : 32'h0000_0013;
                    mem_busy       <= 1'b0;
                end else begin
                    mem_wait <= mem_wait - 1;
                end
            end
        end
    end

    // Fetch must pause once the buffer and output register are both occupied
    always @(posedge clk) begin
        if (rst) begin
            in_flight <= 0;
        end else begin
            if (mem_req && in_flight > `FETCH_FIFO_DEPTH) begin
                other_errors++;
                $display("Memory request issued while the fetch buffer was full");
            end
            in_flight <= in_flight + int'(mem_resp_valid) - int'(dec_valid && issue_ready);
        end
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic set_row(input int i, input instr_t word, input opcode_t op,
                           input int rd, input int rs1, input int rs2,
                           input logic [31:0] imm, input logic ill);
        tbl_instr[i]   = word;
        tbl_opcode[i]  = op;
        tbl_rd[i]      = reg_addr_t'(rd);
        tbl_rs1[i]     = reg_addr_t'(rs1);
        tbl_rs2[i]     = reg_addr_t'(rs2);
        tbl_imm[i]     = imm;
        tbl_illegal[i] = ill;
    endtask

    // Hand-encoded words for every format plus two illegal words
    task automatic load_table;
        set_row(0,  32'hfff1_0093, OP_IMM, 1, 2, 31, 32'hffff_ffff, 1'b0);
        set_row(1,  32'h1234_52b7, LUI, 5, 8, 3, 32'h1234_5000, 1'b0);
        set_row(2,  32'hffff_f517, AUIPC, 10, 31, 31, 32'hffff_f000, 1'b0);
        set_row(3,  32'h0010_00ef, JAL, 1, 0, 1, 32'h0000_0800, 1'b0);
        set_row(4,  32'h0040_8067, JALR, 0, 1, 4, 32'h0000_0004, 1'b0);
        set_row(5,  32'hfe20_8ee3, BRANCH, 29, 1, 2, 32'hffff_fffc, 1'b0);
        set_row(6,  32'h0082_2183, LOAD, 3, 4, 8, 32'h0000_0008, 1'b0);
        set_row(7,  32'hfe53_2c23, STORE, 24, 6, 5, 32'hffff_fff8, 1'b0);
        set_row(8,  32'h0094_03b3, OP, 7, 8, 9, 32'h0000_0000, 1'b0);
        set_row(9,  32'h3001_10f3, SYSTEM, 1, 2, 0, 32'h0000_0300, 1'b0);
        // Custom-0 opcode
        set_row(10, 32'h0000_058b, opcode_t'(7'h0b), 11, 0, 0, 32'h0, 1'b1);
        // OP_IMM pattern with low bits 10
        set_row(11, 32'h0010_0512, opcode_t'(7'h12), 10, 0, 1, 32'h0, 1'b1);
        set_row(12, 32'h7fff_4f93, OP_IMM, 31, 30, 31, 32'h0000_07ff, 1'b0);
        set_row(13, 32'h0041_9863, BRANCH, 16, 3, 4, 32'h0000_0010, 1'b0);
        set_row(14, 32'hffff_f06f, JAL, 0, 31, 31, 32'hffff_fffe, 1'b0);
        set_row(15, 32'h0271_10a3, STORE, 1, 2, 7, 32'h0000_0021, 1'b0);
    endtask

    // Waits for the next accepted output and compares it with row n
    task automatic wait_accept(input int n, output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < wait_limit) begin
            @(posedge clk);
            if (dec_valid && issue_ready) begin
                ok = 1'b1;
                compare_field("dec_pc", dec_pc, `RESET_PC + 32'(4 * n));
                compare_field("dec_opcode", 32'(dec_opcode), 32'(tbl_opcode[n]));
                compare_field("dec_rd", 32'(dec_rd), 32'(tbl_rd[n]));
                compare_field("dec_rs1", 32'(dec_rs1), 32'(tbl_rs1[n]));
                compare_field("dec_rs2", 32'(dec_rs2), 32'(tbl_rs2[n]));
                compare_field("dec_imm", dec_imm, tbl_imm[n]);
                compare_field("dec_illegal", 32'(dec_illegal), 32'(tbl_illegal[n]));
            end
            issue_ready <= 1'($random(seed));
            cycles++;
        end
    endtask

    // Holds ready low and checks that the output register stays put
    task automatic hold_issue;
        logic             held;
        logic [`XLEN-1:0] pc0;
        logic [`XLEN-1:0] imm0;
        reg_addr_t        rd0;
        issue_ready <= 1'b0;
        held = 1'b0;
        repeat (stall_cycles) begin
            @(posedge clk);
            if (held) begin
                compare_field("dec_valid", 32'(dec_valid), 32'd1);
                compare_field("dec_pc", dec_pc, pc0);
                compare_field("dec_imm", dec_imm, imm0);
                compare_field("dec_rd", 32'(dec_rd), 32'(rd0));
            end else if (dec_valid) begin
                // First output seen while stalled must then hold
                held = 1'b1;
                pc0  = dec_pc;
                imm0 = dec_imm;
                rd0  = dec_rd;
            end
        end
        if (!held) begin
            other_errors++;
            $display("No decoded instruction appeared during the issue stall");
        end
    endtask

    initial begin
        bit ok;
        bit aborted;
        clk            = 1'b0;
        rst            = 1'b1;
        fetch_en       = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        issue_ready    = 1'b0;
        aborted        = 1'b0;
        load_table();

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        compare_field("dec_valid", 32'(dec_valid), 32'd0);
        compare_field("mem_req", 32'(mem_req), 32'd0);
        fetch_en    <= 1'b1;
        issue_ready <= 1'b1;

        for (int n = 0; n < num_rows && !aborted; n++) begin
            wait_accept(n, ok);
            if (!ok) begin
                aborted = 1'b1;
                other_errors++;
                $display("Timed out waiting for decoded instruction %0d", n);
            end else if (n == stall_row) begin
                hold_issue();
            end
        end

        // Nothing beyond the table may come out
        if (!aborted) begin
            issue_ready <= 1'b1;
            repeat (10) begin
                @(posedge clk);
                if (dec_valid) begin
                    other_errors++;
                    $display("Extra decoded instruction after the last table row");
                end
            end
        end

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- fetch_decode.f
+incdir+include
rtl/riscv_isa_pkg.sv
rtl/frontend_pkg.sv
rtl/lfsr.sv
rtl/fetch_fifo.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/fetch_decode_top.sv
testbench/fetch_decode_checker.sv
testbench/fetch_decode_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= fetch_decode_tb
FILELIST  ?= fetch_decode.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
